// ==== hdl/saturn_cfg.svh ====
//********************************************************************
// saturn fetch front end configuration
// return stack depth, reset pc and jump length codes
//********************************************************************
`ifndef SATURN_CFG_SVH
`define SATURN_CFG_SVH

// circular return stack, must match the pointer width
`define SATURN_RSTK_DEPTH 8

// first fetch address after reset
`define SATURN_RESET_PC 20'h00000

// jump length codes, offset nibbles minus one
// GOTO / GOSUB
`define SATURN_JLEN_REL3 3'd2
// GOLONG / GOSUBL
`define SATURN_JLEN_REL4 3'd3
// GOVLNG / GOSBVL
`define SATURN_JLEN_ABS5 3'd4

`endif

// ==== hdl/saturn_pkg.sv ====
//********************************************************************
// saturn fetch front end shared types
// vector widths with a meaning and the opcode decoder state encoding
//********************************************************************
`default_nettype none

package saturn_pkg;

    // nibble address, used for the pc and every return stack entry
    typedef logic [19:0] addr_t;

    // one instruction nibble off the bus
    typedef logic [3:0] nibble_t;

    // index into the eight-entry return stack
    typedef logic [2:0] rstk_ptr_t;

    // offset nibble count minus one
    // 2 = rel3, 3 = rel4, 4 = abs5
    typedef logic [2:0] jump_len_t;

    // control-flow decoder states
    typedef enum logic [1:0] {
        DEC_IDLE    = 2'd0,
        // saw a leading 0, next nibble ends the instruction
        DEC_BLOCK_0 = 2'd1,
        // saw a leading 8, next nibble selects the long jump
        DEC_BLOCK_8 = 2'd2,
        // offset nibbles are being consumed by the pc block
        DEC_JUMP    = 2'd3
    } dec_state_t;

endpackage

`default_nettype wire

// ==== hdl/saturn_phase_gen.sv ====
//********************************************************************
// saturn four-phase sequencer
// one-hot phases, advanced on enabled unstalled cycles only
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module saturn_phase_gen (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_clk_en,
    input  wire        i_bus_busy,
    input  wire        i_exec_busy,
    input  wire        i_init_busy,
    output logic [3:0] o_phases,
    output logic       o_running
);

    logic [1:0] phase_ctr;

    // stall from the bus, the execution side or the stack clear
    assign o_running = i_clk_en && !i_bus_busy && !i_exec_busy && !i_init_busy;

    // counter to one-hot
    assign o_phases = 4'b0001 << phase_ctr;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_ctr <= 2'd0;
        end else if (o_running) begin
            // wraps 3 -> 0
            phase_ctr <= phase_ctr + 2'd1;
        end
    end

    // exactly one phase active at any time
    assert property (@(posedge i_clk) $onehot(o_phases));

endmodule

`default_nettype wire

// ==== hdl/saturn_ctrl_decode.sv ====
//********************************************************************
// saturn control-flow opcode decoder
// picks out GOTO/GOSUB, the 8C-8F long jumps and the 0x returns
//********************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "saturn_cfg.svh"

module saturn_ctrl_decode (
    input  wire                   i_clk,
    input  wire                   i_reset,
    input  wire  [3:0]            i_phases,
    input  wire                   i_running,
    input  wire  saturn_pkg::nibble_t i_nibble,
    input  wire                   i_jump_done,
    output logic                  o_jump_instr,
    output saturn_pkg::jump_len_t o_jump_len,
    output logic                  o_push_pc,
    output logic                  o_block_0x
);

    saturn_pkg::dec_state_t state;
    saturn_pkg::dec_state_t state_nxt;
    saturn_pkg::jump_len_t  jump_len_nxt;
    logic                   push_pc_nxt;
    logic                   sample;

    // nibbles are consumed in phase 2 of a running cycle
    assign sample = i_running && i_phases[2];

    always_comb begin
        state_nxt    = state;
        jump_len_nxt = o_jump_len;
        push_pc_nxt  = o_push_pc;

        case (state)
            saturn_pkg::DEC_IDLE: begin
                if (sample) begin
                    case (i_nibble)
                        // GOTO rel3
                        4'h6: begin
                            state_nxt    = saturn_pkg::DEC_JUMP;
                            jump_len_nxt = `SATURN_JLEN_REL3;
                            push_pc_nxt  = 1'b0;
                        end
                        // GOSUB rel3
                        4'h7: begin
                            state_nxt    = saturn_pkg::DEC_JUMP;
                            jump_len_nxt = `SATURN_JLEN_REL3;
                            push_pc_nxt  = 1'b1;
                        end
                        4'h0: state_nxt = saturn_pkg::DEC_BLOCK_0;
                        4'h8: state_nxt = saturn_pkg::DEC_BLOCK_8;
                        // single nibble no-ops
                        default: state_nxt = saturn_pkg::DEC_IDLE;
                    endcase
                end
            end

            saturn_pkg::DEC_BLOCK_0: begin
                // second nibble closes the 0x instruction
                // the pc block handles 00..03 as a pop
                if (sample) begin
                    state_nxt = saturn_pkg::DEC_IDLE;
                end
            end

            saturn_pkg::DEC_BLOCK_8: begin
                if (sample) begin
                    if (i_nibble[3:2] == 2'b11) begin
                        // 8C/8E rel4, 8D/8F abs5
                        // bit 1 marks the calls
                        state_nxt    = saturn_pkg::DEC_JUMP;
                        jump_len_nxt = i_nibble[0] ? `SATURN_JLEN_ABS5 : `SATURN_JLEN_REL4;
                        push_pc_nxt  = i_nibble[1];
                    end else begin
                        // other 8x, two nibble no-op
                        state_nxt = saturn_pkg::DEC_IDLE;
                    end
                end
            end

            saturn_pkg::DEC_JUMP: begin
                // offset nibbles belong to the pc block
                if (i_jump_done) begin
                    state_nxt = saturn_pkg::DEC_IDLE;
                end
            end

            default: state_nxt = saturn_pkg::DEC_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= saturn_pkg::DEC_IDLE;
            o_jump_len <= `SATURN_JLEN_REL3;
            o_push_pc  <= 1'b0;
        end else begin
            state      <= state_nxt;
            o_jump_len <= jump_len_nxt;
            o_push_pc  <= push_pc_nxt;
        end
    end

    // levels towards the pc block
    assign o_jump_instr = (state == saturn_pkg::DEC_JUMP);
    assign o_block_0x   = (state == saturn_pkg::DEC_BLOCK_0);

    // the pc block only understands three offset lengths
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_jump_instr |-> (o_jump_len inside
            {`SATURN_JLEN_REL3, `SATURN_JLEN_REL4, `SATURN_JLEN_ABS5}));

endmodule

`default_nettype wire

// ==== hdl/saturn_regs_pc_rstk.sv ====
//********************************************************************
// saturn program counter and return stack
// pc increment, jump offset assembly, circular eight-deep stack
// with push, pop and a debugger read port
//********************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "saturn_cfg.svh"

module saturn_regs_pc_rstk (
    input  wire                      i_clk,
    input  wire                      i_clk_en,
    input  wire                      i_reset,
    input  wire  [3:0]               i_phases,
    input  wire                      i_bus_busy,
    input  wire                      i_exec_busy,
    input  wire  saturn_pkg::nibble_t   i_nibble,
    input  wire                      i_jump_instr,
    input  wire  saturn_pkg::jump_len_t i_jump_length,
    input  wire                      i_block_0x,
    input  wire                      i_push_pc,
    input  wire  saturn_pkg::rstk_ptr_t i_dbg_rstk_ptr,
    output saturn_pkg::addr_t        o_current_pc,
    output logic                     o_jump_done,
    output logic                     o_init_busy,
    output saturn_pkg::addr_t        o_dbg_rstk_val,
    output saturn_pkg::rstk_ptr_t    o_reg_rstk_ptr
);

    localparam saturn_pkg::rstk_ptr_t RSTK_TOP =
        saturn_pkg::rstk_ptr_t'(`SATURN_RSTK_DEPTH - 1);

    saturn_pkg::addr_t     reg_pc;
    saturn_pkg::rstk_ptr_t reg_rstk_ptr;
    saturn_pkg::addr_t     reg_rstk [`SATURN_RSTK_DEPTH];

    logic                  init_busy;
    saturn_pkg::rstk_ptr_t init_counter;

    logic                  jump_decode;
    saturn_pkg::jump_len_t jump_counter;
    saturn_pkg::addr_t     jump_base;
    logic [15:0]           jump_offset;
    saturn_pkg::addr_t     jump_next_offset;
    saturn_pkg::rstk_ptr_t push_ptr;

    saturn_pkg::addr_t     return_addr;
    saturn_pkg::rstk_ptr_t pop_ptr;

    logic                  run;
    logic                  do_jump;
    logic                  jump_rel3;
    logic                  jump_rel4;
    logic                  jump_relative;
    logic                  jump_last;
    logic                  is_rtn;

    // nothing moves while the bus or execution side holds us
    assign run = i_clk_en && !i_bus_busy && !i_exec_busy;

    // new jumps only once the stack is cleared
    assign do_jump = !init_busy && i_jump_instr;

    assign jump_rel3     = (i_jump_length == `SATURN_JLEN_REL3);
    assign jump_rel4     = (i_jump_length == `SATURN_JLEN_REL4);
    assign jump_relative = jump_rel3 || jump_rel4;

    // final offset nibble arrives in this phase 2
    assign jump_last = run && i_phases[2] && i_jump_instr && jump_decode
                       && (jump_counter == i_jump_length);

    // RTNSXM, RTN, RTNSC, RTNCC
    assign is_rtn = run && i_phases[2] && i_block_0x && (i_nibble[3:2] == 2'b00);

    // little-endian offset, sign taken from the last nibble
    always_comb begin
        case (jump_counter)
            3'd0: jump_next_offset = {16'h0000, i_nibble};
            3'd1: jump_next_offset = {12'h000, i_nibble, jump_offset[3:0]};
            3'd2: jump_next_offset = {{8{jump_rel3 & i_nibble[3]}}, i_nibble,
                                      jump_offset[7:0]};
            3'd3: jump_next_offset = {{4{jump_rel4 & i_nibble[3]}}, i_nibble,
                                      jump_offset[11:0]};
            3'd4: jump_next_offset = {i_nibble, jump_offset[15:0]};
            default: jump_next_offset = 20'h00000;
        endcase
    end

    always_ff @(posedge i_clk) begin
        // wipe one stack entry per clock after reset
        if (init_busy) begin
            reg_rstk[init_counter] <= 20'h00000;
            init_counter           <= init_counter + 3'd1;
            if (init_counter == RSTK_TOP) begin
                init_busy <= 1'b0;
            end
        end

        if (run) begin
            if (i_phases[1]) begin
                reg_pc <= reg_pc + 20'd1;
                // pre-read the top of stack for a possible return
                return_addr <= reg_rstk[reg_rstk_ptr];
                pop_ptr     <= reg_rstk_ptr - 3'd1;
            end

            // jump start, pc already points at the first offset nibble
            // calls use the address after the offset as base
            if (i_phases[3] && do_jump && !jump_decode) begin
                jump_counter <= 3'd0;
                jump_decode  <= 1'b1;
                push_ptr     <= reg_rstk_ptr + 3'd1;
                if (i_push_pc) begin
                    jump_base <= reg_pc + saturn_pkg::addr_t'(i_jump_length) + 20'd1;
                end else begin
                    jump_base <= reg_pc;
                end
            end

            // one offset nibble per phase 2
            if (i_phases[2] && i_jump_instr && jump_decode) begin
                jump_offset  <= jump_next_offset[15:0];
                jump_counter <= jump_counter + 3'd1;
                if (jump_last) begin
                    jump_decode <= 1'b0;
                    reg_pc      <= jump_relative ? jump_base + jump_next_offset
                                                 : jump_next_offset;
                    // pc was bumped in phase 1, so it is the return address
                    if (i_push_pc) begin
                        reg_rstk[push_ptr] <= reg_pc;
                        reg_rstk_ptr       <= push_ptr;
                    end
                end
            end

            // pop, the vacated entry reads back as zero
            if (is_rtn) begin
                reg_pc                 <= return_addr;
                reg_rstk[reg_rstk_ptr] <= 20'h00000;
                reg_rstk_ptr           <= pop_ptr;
            end
        end

        if (i_reset) begin
            init_busy    <= 1'b1;
            init_counter <= 3'd0;
            jump_decode  <= 1'b0;
            jump_counter <= 3'd0;
            reg_pc       <= `SATURN_RESET_PC;
            reg_rstk_ptr <= RSTK_TOP;
        end
    end

    assign o_current_pc   = reg_pc;
    assign o_jump_done    = jump_last;
    assign o_init_busy    = init_busy;
    assign o_dbg_rstk_val = reg_rstk[i_dbg_rstk_ptr];
    assign o_reg_rstk_ptr = reg_rstk_ptr;

    // sequencer parks in phase 0 for the whole clear, so no jump can finish
    assert property (@(posedge i_clk) disable iff (i_reset)
        init_busy |-> (i_phases[0] && !o_jump_done));

endmodule

`default_nettype wire

// ==== hdl/saturn_fetch_core.sv ====
//********************************************************************
// saturn instruction fetch front end
// one nibble per four-phase cycle from the nibble bus, pc and stack
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module saturn_fetch_core (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_clk_en,
    input  wire                         i_bus_busy,
    input  wire                         i_exec_busy,
    input  wire  saturn_pkg::nibble_t   i_nibble,
    input  wire  saturn_pkg::rstk_ptr_t i_dbg_rstk_ptr,
    output saturn_pkg::addr_t           o_fetch_addr,
    output logic                        o_fetch_strobe,
    output saturn_pkg::rstk_ptr_t       o_rstk_ptr,
    output saturn_pkg::addr_t           o_dbg_rstk_val
);

    logic [3:0]            phases;
    logic                  running;
    logic                  init_busy;
    logic                  jump_instr;
    saturn_pkg::jump_len_t jump_len;
    logic                  push_pc;
    logic                  block_0x;
    logic                  jump_done;
    saturn_pkg::nibble_t   fetched_nibble;

    // nibble request in phase 0 of every running cycle
    assign o_fetch_strobe = phases[0] && running;

    // hold the requested nibble, the pc moves on in phase 1
    always_ff @(posedge i_clk) begin
        if (o_fetch_strobe) begin
            fetched_nibble <= i_nibble;
        end
    end

    saturn_phase_gen phase_gen0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clk_en    (i_clk_en),
        .i_bus_busy  (i_bus_busy),
        .i_exec_busy (i_exec_busy),
        .i_init_busy (init_busy),
        .o_phases    (phases),
        .o_running   (running)
    );

    saturn_ctrl_decode ctrl_decode0 (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_phases     (phases),
        .i_running    (running),
        .i_nibble     (fetched_nibble),
        .i_jump_done  (jump_done),
        .o_jump_instr (jump_instr),
        .o_jump_len   (jump_len),
        .o_push_pc    (push_pc),
        .o_block_0x   (block_0x)
    );

    saturn_regs_pc_rstk regs_pc_rstk0 (
        .i_clk          (i_clk),
        .i_clk_en       (i_clk_en),
        .i_reset        (i_reset),
        .i_phases       (phases),
        .i_bus_busy     (i_bus_busy),
        .i_exec_busy    (i_exec_busy),
        .i_nibble       (fetched_nibble),
        .i_jump_instr   (jump_instr),
        .i_jump_length  (jump_len),
        .i_block_0x     (block_0x),
        .i_push_pc      (push_pc),
        .i_dbg_rstk_ptr (i_dbg_rstk_ptr),
        .o_current_pc   (o_fetch_addr),
        .o_jump_done    (jump_done),
        .o_init_busy    (init_busy),
        .o_dbg_rstk_val (o_dbg_rstk_val),
        .o_reg_rstk_ptr (o_rstk_ptr)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//**********************************************************************
// testbench clock source, 40 ns period, reset held for 8 cycles
//**********************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (8) @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_saturn_fetch_core.sv ====
//**********************************************************************
// testbench for the saturn fetch front end
// sparse program memory, table of programs with expected fetch traces
//**********************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_saturn_fetch_core;

    localparam int NTESTS = 7;
    localparam int NROWS  = 88;
    localparam int TLEN   = 20;
    localparam int WAIT_MAX = 200;

    // goto rows 0..7, long jumps 8..20, calls 21..37, returns 38..51
    localparam logic [23:0] FIXED_ROWS [52] = '{
        24'h000006, 24'h000010, 24'h000021, 24'h000030,
        24'h000116, 24'h000124, 24'h00013F, 24'h00014F,
        24'h000008, 24'h00001C, 24'h000020, 24'h000030, 24'h000041, 24'h000050,
        24'h001028, 24'h00103D, 24'h001045, 24'h001054, 24'h001063, 24'h001072,
        24'h001081,
        24'h000007, 24'h000010, 24'h000022, 24'h000030, 24'h000248, 24'h00025E,
        24'h000260, 24'h000270, 24'h000281, 24'h000290, 24'h0012A8, 24'h0012BF,
        24'h0012C0, 24'h0012D0, 24'h0012E0, 24'h0012F0, 24'h001303,
        24'h000007, 24'h000010, 24'h000021, 24'h000030, 24'h000147, 24'h00015C,
        24'h000160, 24'h000170, 24'h000180, 24'h000193, 24'h000240, 24'h000251,
        24'h000040, 24'h000051};

    wire        clk;
    wire        gen_reset;
    logic       tb_reset;
    logic       clk_en;
    logic       bus_busy;
    logic       exec_busy;
    logic [2:0] dbg_ptr;
    wire [19:0] fetch_addr;
    wire        fetch_strobe;
    wire [2:0]  rstk_ptr;
    wire [19:0] dbg_val;
    wire [3:0]  nibble;

    // program rows as {address, nibble}
    logic [23:0] prog [NROWS];
    int          cur_first;
    int          cur_rows;

    string       names [NTESTS];
    int          first [NTESTS];
    int          rows [NTESTS];
    int          nstrobes [NTESTS];
    bit          stall [NTESTS];
    logic [19:0] exp_trace [NTESTS][TLEN];
    logic [19:0] exp_stack [NTESTS][8];
    logic [2:0]  exp_ptr [NTESTS];

    int          errors;
    int          tests_run;
    bit          timed_out;
    logic [31:0] rng;

    tb_clock_gen clock_gen0 (.o_clk(clk), .o_reset(gen_reset));

    saturn_fetch_core dut0 (
        .i_clk          (clk),
        .i_reset        (gen_reset | tb_reset),
        .i_clk_en       (clk_en),
        .i_bus_busy     (bus_busy),
        .i_exec_busy    (exec_busy),
        .i_nibble       (nibble),
        .i_dbg_rstk_ptr (dbg_ptr),
        .o_fetch_addr   (fetch_addr),
        .o_fetch_strobe (fetch_strobe),
        .o_rstk_ptr     (rstk_ptr),
        .o_dbg_rstk_val (dbg_val)
    );

    // unlisted addresses read as a one-nibble no-op hashed from the address
    function automatic logic [3:0] mem_read(input logic [19:0] a, input int f, input int n);
        logic [3:0] v;
        v = a[3:0] ^ a[7:4] ^ a[11:8] ^ a[15:12] ^ a[19:16];
        if (v == 4'h0 || v == 4'h6 || v == 4'h7 || v == 4'h8) begin
            v = 4'h9 + {2'b00, v[1:0]};
        end
        for (int i = f; i < f + n; i++) begin
            if (prog[i][23:4] == a) begin
                v = prog[i][3:0];
            end
        end
        return v;
    endfunction

    assign nibble = mem_read(fetch_addr, cur_first, cur_rows);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input string what,
                         input logic [19:0] exp, input logic [19:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s expected %05h actual %05h", name, what, exp, act);
        end
    endtask

    // wait for the next strobe
    // stall levels redrawn every falling edge in stall mode
    task automatic wait_strobe(input int t, output logic [19:0] addr);
        int  n;
        bit  got;
        got = 1'b0;
        n = 0;
        while (!got && n < WAIT_MAX) begin
            @(negedge clk);
            if (stall[t]) begin
                rng = xorshift(rng);
                bus_busy  = rng[0] & rng[1];
                exec_busy = rng[2] & rng[3];
                clk_en    = ~(rng[4] & rng[5]);
            end
            #1;
            got = fetch_strobe;
            addr = fetch_addr;
            n++;
        end
        if (!got) begin
            timed_out = 1'b1;
            $display("ERROR: no fetch strobe within %0d cycles in test %s",
                     WAIT_MAX, names[t]);
        end
    endtask

    task automatic run_test(input int t);
        logic [19:0] addr;
        int          err0;
        err0 = errors;
        @(negedge clk);
        tb_reset  = 1'b1;
        clk_en    = 1'b1;
        bus_busy  = 1'b0;
        exec_busy = 1'b0;
        cur_first = first[t];
        cur_rows  = rows[t];
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
        end
        tb_reset = 1'b0;
        for (int k = 0; k < nstrobes[t] && !timed_out; k++) begin
            wait_strobe(t, addr);
            if (!timed_out && k < TLEN) begin
                check(names[t], $sformatf("fetch %0d", k), exp_trace[t][k], addr);
            end
        end
        if (!timed_out) begin
            // freeze the core while the debugger reads the stack
            exec_busy = 1'b1;
            check(names[t], "rstk_ptr", {17'h0, exp_ptr[t]}, {17'h0, rstk_ptr});
            for (int s = 0; s < 8; s++) begin
                dbg_ptr = 3'(s);
                #1;
                check(names[t], $sformatf("rstk[%0d]", s), exp_stack[t][s], dbg_val);
            end
        end
        $display("test %s %s, %0d mismatches", names[t],
                 (errors == err0 && !timed_out) ? "ok" : "bad", errors - err0);
    endtask

    initial begin
        logic [19:0] a;
        int          w;
        tb_reset  = 1'b0;
        clk_en    = 1'b1;
        bus_busy  = 1'b0;
        exec_busy = 1'b0;
        dbg_ptr   = 3'd0;
        cur_first = 0;
        cur_rows  = 0;
        errors    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        rng       = 32'hd070;

        for (int i = 0; i < 52; i++) begin
            prog[i] = FIXED_ROWS[i];
        end
        // nine chained GOSUBs 16 nibbles apart
        for (int k = 0; k < 9; k++) begin
            a = 20'(16 * k);
            prog[52 + 4 * k] = {a, 4'h7};
            prog[53 + 4 * k] = {a + 20'h1, 4'hC};
            prog[54 + 4 * k] = {a + 20'h2, 4'h0};
            prog[55 + 4 * k] = {a + 20'h3, 4'h0};
        end

        names    = '{"seq", "goto", "long_jumps", "calls", "returns", "wrap", "calls_stall"};
        first    = '{0, 0, 8, 21, 38, 52, 21};
        rows     = '{0, 8, 13, 17, 14, 36, 17};
        nstrobes = '{20, 20, 20, 20, 20, 37, 20};
        stall    = '{0, 0, 0, 0, 0, 0, 1};
        exp_ptr  = '{3'd7, 3'd7, 3'd7, 3'd2, 3'd7, 3'd0, 3'd2};
        for (int t = 0; t < NTESTS; t++) begin
            for (int s = 0; s < 8; s++) begin
                exp_stack[t][s] = 20'h0;
            end
        end
        for (int j = 0; j < TLEN; j++) begin
            exp_trace[0][j] = 20'(j);
            exp_trace[5][j] = 20'(16 * (j / 4) + j % 4);
        end
        exp_trace[1] = '{20'h0, 20'h1, 20'h2, 20'h3, 20'h11, 20'h12, 20'h13, 20'h14,
            20'h6, 20'h7, 20'h8, 20'h9, 20'hA, 20'hB, 20'hC, 20'hD,
            20'hE, 20'hF, 20'h10, 20'h11};
        exp_trace[2] = '{20'h0, 20'h1, 20'h2, 20'h3, 20'h4, 20'h5, 20'h102, 20'h103,
            20'h104, 20'h105, 20'h106, 20'h107, 20'h108, 20'h12345, 20'h12346,
            20'h12347, 20'h12348, 20'h12349, 20'h1234A, 20'h1234B};
        exp_trace[3] = '{20'h0, 20'h1, 20'h2, 20'h3, 20'h24, 20'h25, 20'h26, 20'h27,
            20'h28, 20'h29, 20'h12A, 20'h12B, 20'h12C, 20'h12D, 20'h12E, 20'h12F,
            20'h130, 20'h30000, 20'h30001, 20'h30002};
        exp_trace[4] = '{20'h0, 20'h1, 20'h2, 20'h3, 20'h14, 20'h15, 20'h16, 20'h17,
            20'h24, 20'h25, 20'h18, 20'h19, 20'h4, 20'h5, 20'h0, 20'h1,
            20'h2, 20'h3, 20'h14, 20'h15};
        exp_trace[6] = exp_trace[3];
        exp_stack[3][0] = 20'h4;
        exp_stack[3][1] = 20'h2A;
        exp_stack[3][2] = 20'h131;
        exp_stack[6] = exp_stack[3];
        // the empty-stack pop leaves the next call at slot 7
        exp_stack[4][7] = 20'h4;
        // ninth call lands back in slot 0
        exp_stack[5][0] = 20'h84;
        for (int s = 1; s < 8; s++) begin
            exp_stack[5][s] = 20'(16 * s + 4);
        end

        w = 0;
        while (gen_reset && w < 50) begin
            @(negedge clk);
            w++;
        end
        if (gen_reset) begin
            timed_out = 1'b1;
            $display("ERROR: power-on reset never released");
        end

        for (int t = 0; t < NTESTS && !timed_out; t++) begin
            run_test(t);
            tests_run++;
        end

        $display("tests run %0d, mismatches %0d, timeouts %0d",
                 tests_run, errors, timed_out ? 1 : 0);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== saturn_fetch_core.f ====
+incdir+hdl
hdl/saturn_pkg.sv
hdl/saturn_phase_gen.sv
hdl/saturn_ctrl_decode.sv
hdl/saturn_regs_pc_rstk.sv
hdl/saturn_fetch_core.sv
testbench/tb_clock_gen.sv
testbench/tb_saturn_fetch_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fetch core testbench with Verilator and run it
# the run counts as failed if the log holds the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Ihdl -f saturn_fetch_core.f \
    --top-module tb_saturn_fetch_core -o sim_saturn_fetch_core \
    > build.log 2>&1 \
    && ./obj_dir/sim_saturn_fetch_core > sim.log 2>&1 \
    || { cat build.log sim.log 2> /dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }
